// File: include/ras_defines.svh
`ifndef RAS_DEFINES_SVH
`define RAS_DEFINES_SVH

// ************************************************************
// return address stack geometry
// ************************************************************

// entry count, must stay a power of two so the wrap bit
// falls out of a plain pointer increment
`define RAS_SIZE 16
`define RAS_WIDTH 4             // log2 of stack size

// ************************************************************
// fetch addressing
// ************************************************************

`define VADDR_WIDTH 39          // sv39 virtual address
`define INST_OFFSET 1           // halfword granule
`define SLOT_OFFSET_WIDTH 4     // slot index in a fetch block

`endif

// File: logic/bpu_types_pkg.sv
package bpu_types_pkg;

    // ************************************************************
    // branch slot classification
    // ************************************************************

    typedef enum logic [2:0] {
        DIRECT   = 3'd0,        // conditional or jal without link
        INDIRECT = 3'd1,        // jalr without link
        CALL     = 3'd2,
        RET      = 3'd3,
        RET_CALL = 3'd4         // jalr that returns and links
    } br_type_t;

    // ************************************************************
    // stack operation
    // ************************************************************

    // bit 0 pops, bit 1 pushes
    typedef enum logic [1:0] {
        RAS_NONE     = 2'b00,
        RAS_POP      = 2'b01,
        RAS_PUSH     = 2'b10,
        RAS_POP_PUSH = 2'b11    // replace the top entry
    } ras_op_t;

endpackage

// File: logic/ras_pkg.sv
`include "ras_defines.svh"

package ras_pkg;

    // ************************************************************
    // stack contents and pointer snapshot
    // ************************************************************

    // one return address
    typedef logic [`VADDR_WIDTH-1:0] ras_entry_t;

    // pointer state travelling with each prediction,
    // dir bits toggle every time the pointer wraps
    typedef struct packed {
        logic [`RAS_WIDTH-1:0] top;
        logic                  tdir;
        logic [`RAS_WIDTH-1:0] bottom;
        logic                  bdir;
    } ras_ckpt_t;

endpackage

// File: logic/ras_slot_decode.sv
`include "ras_defines.svh"

module ras_slot_decode (
    input  logic [`VADDR_WIDTH-1:0]       start_addr,
    input  logic [`SLOT_OFFSET_WIDTH-1:0] offset,
    input  bpu_types_pkg::br_type_t       br_type,
    input  logic                          rvc,
    output bpu_types_pkg::ras_op_t        op,
    output ras_pkg::ras_entry_t           ret_addr
);
    import bpu_types_pkg::*;

    localparam int PAD_WIDTH = `VADDR_WIDTH - `SLOT_OFFSET_WIDTH - `INST_OFFSET;

    logic [`VADDR_WIDTH-1:0] slot_pc;
    logic [`VADDR_WIDTH-1:0] inst_len;

    // ************************************************************
    // branch class to stack operation
    // ************************************************************

    always_comb begin
        case (br_type)
            CALL:     op = RAS_PUSH;
            RET:      op = RAS_POP;
            RET_CALL: op = RAS_POP_PUSH;    // pop first, then link
            default:  op = RAS_NONE;
        endcase
    end

    // ************************************************************
    // fall-through address
    // ************************************************************

    // pc of the branch itself
    assign slot_pc = start_addr + {{PAD_WIDTH{1'b0}}, offset, {`INST_OFFSET{1'b0}}};

    assign inst_len = {{(`VADDR_WIDTH - 3){1'b0}}, ~rvc, rvc, 1'b0};   // 2 or 4 bytes

    assign ret_addr = slot_pc + inst_len;

endmodule

// File: logic/ras_stack.sv
`include "ras_defines.svh"

module ras_stack (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   lookup_valid,
    input  bpu_types_pkg::ras_op_t lookup_op,
    input  ras_pkg::ras_entry_t    lookup_addr,
    input  logic                   squash,
    input  logic                   squash_front,
    input  bpu_types_pkg::ras_op_t squash_op,
    input  ras_pkg::ras_entry_t    squash_addr,
    input  ras_pkg::ras_ckpt_t     squash_ckpt,
    input  logic                   commit_valid,
    input  bpu_types_pkg::ras_op_t commit_op,
    input  ras_pkg::ras_entry_t    commit_addr,
    output ras_pkg::ras_entry_t    spec_entry,
    output ras_pkg::ras_entry_t    commit_entry,
    output logic                   stale,
    output logic                   empty,
    output ras_pkg::ras_ckpt_t     ckpt
);
    import bpu_types_pkg::*;
    import ras_pkg::*;

    function automatic logic [`RAS_SIZE-1:0] onehot(input logic [`RAS_WIDTH-1:0] idx);
        logic [`RAS_SIZE-1:0] vec;
        vec = '0;
        vec[idx] = 1'b1;
        return vec;
    endfunction

    logic [`RAS_WIDTH-1:0] top;
    logic                  tdir;
    logic [`RAS_WIDTH-1:0] bottom;
    logic                  bdir;
    logic [`RAS_WIDTH-1:0] commit_top;
    logic [`RAS_SIZE-1:0]  speculate;
    logic [`RAS_SIZE-1:0]  spec_pop;
    logic [`RAS_SIZE-1:0]  spec_push;
    ras_entry_t            spec_mem [`RAS_SIZE];
    ras_entry_t            commit_mem [`RAS_SIZE];

    logic                  full;
    logic [`RAS_WIDTH-1:0] top_m1;
    logic                  ckpt_full;
    logic                  ckpt_empty;

    ras_op_t               act_op;
    ras_entry_t            act_addr;
    logic [`RAS_WIDTH:0]   base_t;
    logic [`RAS_WIDTH:0]   base_b;
    logic [`RAS_WIDTH:0]   next_t;
    logic [`RAS_WIDTH:0]   next_b;
    logic                  base_full;
    logic                  base_empty;
    logic                  act_pop;
    logic                  act_push;
    logic [`RAS_WIDTH-1:0] base_top_m1;
    logic [`RAS_WIDTH-1:0] waddr;

    logic [`RAS_SIZE-1:0]  ckpt_top_mask;
    logic [`RAS_SIZE-1:0]  ckpt_bottom_mask;
    logic [`RAS_SIZE-1:0]  ckpt_valid_mask;
    logic [`RAS_SIZE-1:0]  speculate_mask;
    logic                  clear_spec;
    logic [`RAS_SIZE-1:0]  pop_bit;
    logic [`RAS_SIZE-1:0]  push_bit;

    logic                  commit_we;
    logic [`RAS_WIDTH-1:0] commit_waddr;
    logic [`RAS_SIZE-1:0]  commit_mask;

    // ************************************************************
    // occupancy
    // ************************************************************

    assign full       = (tdir ^ bdir) & (top == bottom);
    assign empty      = (tdir == bdir) & (top == bottom);
    assign ckpt_full  = (squash_ckpt.tdir ^ squash_ckpt.bdir) &
                        (squash_ckpt.top == squash_ckpt.bottom);
    assign ckpt_empty = (squash_ckpt.tdir == squash_ckpt.bdir) &
                        (squash_ckpt.top == squash_ckpt.bottom);

    // ************************************************************
    // operation select, squash over lookup
    // ************************************************************

    assign act_op     = squash ? squash_op : (lookup_valid ? lookup_op : RAS_NONE);
    assign act_addr   = squash ? squash_addr : lookup_addr;
    assign base_t     = squash ? {squash_ckpt.tdir, squash_ckpt.top} : {tdir, top};
    assign base_b     = squash ? {squash_ckpt.bdir, squash_ckpt.bottom} : {bdir, bottom};
    assign base_full  = squash ? ckpt_full : full;
    assign base_empty = squash ? ckpt_empty : empty;

    assign act_pop     = act_op[0] & ~base_empty;     // empty pop is a no-op
    assign act_push    = act_op[1];
    assign base_top_m1 = base_t[`RAS_WIDTH-1:0] - 1'b1;
    assign waddr       = act_pop ? base_top_m1 : base_t[`RAS_WIDTH-1:0];

    // wrap bit rides along as the pointer msb
    always_comb begin
        next_t = base_t;
        next_b = base_b;
        if (act_push && !act_pop) begin
            next_t = base_t + 1'b1;
            if (base_full) begin
                next_b = base_b + 1'b1;   // drop the oldest
            end
        end else if (act_pop && !act_push) begin
            next_t = base_t - 1'b1;
        end
    end

    // ************************************************************
    // speculation tracking
    // ************************************************************

    always_comb begin
        for (int i = 0; i < `RAS_SIZE; i++) begin
            ckpt_top_mask[i]    = i < squash_ckpt.top;
            ckpt_bottom_mask[i] = i < squash_ckpt.bottom;
        end
    end

    // live region between bottom and top, inverted once wrapped
    assign ckpt_valid_mask = ckpt_top_mask ^ ckpt_bottom_mask ^
                             {`RAS_SIZE{squash_ckpt.tdir ^ squash_ckpt.bdir}};
    // popped then re-pushed inside the restored region
    assign speculate_mask  = ckpt_valid_mask & spec_pop & spec_push;
    assign clear_spec      = squash & ~squash_front;
    assign pop_bit         = act_pop ? onehot(base_top_m1) : '0;
    assign push_bit        = act_push ? onehot(waddr) : '0;

    // ************************************************************
    // commit side
    // ************************************************************

    assign commit_we    = commit_valid & commit_op[1];
    assign commit_waddr = commit_op[0] ? commit_top - 1'b1 : commit_top;
    assign commit_mask  = commit_we ? onehot(commit_waddr) : '0;

    // ************************************************************
    // read and checkpoint
    // ************************************************************

    assign top_m1       = top - 1'b1;
    assign spec_entry   = spec_mem[top_m1];
    assign commit_entry = commit_mem[top_m1];
    assign stale        = speculate[top_m1] & ~spec_push[top_m1];

    assign ckpt.top    = top;
    assign ckpt.tdir   = tdir;
    assign ckpt.bottom = bottom;
    assign ckpt.bdir   = bdir;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            top        <= '0;
            tdir       <= 1'b0;
            bottom     <= '0;
            bdir       <= 1'b0;
            commit_top <= '0;
            speculate  <= '0;
            spec_pop   <= '0;
            spec_push  <= '0;
        end else begin
            {tdir, top}    <= next_t;
            {bdir, bottom} <= next_b;
            spec_pop       <= (clear_spec ? '0 : spec_pop) | pop_bit;
            spec_push      <= (clear_spec ? '0 : spec_push) | push_bit;
            speculate      <= (speculate | (speculate_mask & {`RAS_SIZE{clear_spec}})) &
                              ~commit_mask;   // commit repairs the slot
            if (commit_valid) begin
                case (commit_op)
                    RAS_PUSH: commit_top <= commit_top + 1'b1;
                    RAS_POP:  commit_top <= commit_top - 1'b1;
                    default:  commit_top <= commit_top;
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (act_push) begin
            spec_mem[waddr] <= act_addr;
        end
        if (commit_we) begin
            commit_mem[commit_waddr] <= commit_addr;
        end
    end

endmodule

// File: logic/ras_target_select.sv
`include "ras_defines.svh"

module ras_target_select (
    input  logic                    clk,
    input  logic                    rst,
    input  ras_pkg::ras_entry_t     spec_entry,
    input  ras_pkg::ras_entry_t     commit_entry,
    input  logic                    stale,
    input  logic                    empty,
    input  ras_pkg::ras_ckpt_t      ckpt,
    input  logic                    lookup,
    output logic                    pred_valid,
    output logic [`VADDR_WIDTH-1:0] pred_target,
    output ras_pkg::ras_ckpt_t      pred_ckpt
);
    import ras_pkg::*;

    ras_entry_t target;
    logic       hit;

    // ************************************************************
    // entry select
    // ************************************************************

    // overwritten speculative slot falls back to commit copy
    assign target = stale ? commit_entry : spec_entry;

    assign hit = lookup & ~empty;

    // ************************************************************
    // prediction register
    // ************************************************************

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pred_valid <= 1'b0;
        end else begin
            pred_valid <= hit;        // one cycle pulse per lookup
        end
    end

    // pre-operation state, also kept for an empty stack
    always_ff @(posedge clk) begin
        if (lookup) begin
            pred_target <= target;
            pred_ckpt   <= ckpt;
        end
    end

endmodule

// File: logic/ras_predictor.sv
`include "ras_defines.svh"

module ras_predictor (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          lookup,
    input  logic [`VADDR_WIDTH-1:0]       lookup_start_addr,
    input  logic [`SLOT_OFFSET_WIDTH-1:0] lookup_offset,
    input  bpu_types_pkg::br_type_t       lookup_br_type,
    input  logic                          lookup_rvc,
    input  logic                          squash,
    input  logic                          squash_front,
    input  logic [`VADDR_WIDTH-1:0]       squash_start_addr,
    input  logic [`SLOT_OFFSET_WIDTH-1:0] squash_offset,
    input  bpu_types_pkg::br_type_t       squash_br_type,
    input  logic                          squash_rvc,
    input  ras_pkg::ras_ckpt_t            squash_ckpt,
    input  logic                          update,
    input  logic                          update_taken,
    input  logic [`VADDR_WIDTH-1:0]       update_start_addr,
    input  logic [`SLOT_OFFSET_WIDTH-1:0] update_offset,
    input  bpu_types_pkg::br_type_t       update_br_type,
    input  logic                          update_rvc,
    output logic                          pred_valid,
    output logic [`VADDR_WIDTH-1:0]       pred_target,
    output ras_pkg::ras_ckpt_t            pred_ckpt
);
    import bpu_types_pkg::*;
    import ras_pkg::*;

    ras_op_t    lookup_op;
    ras_entry_t lookup_ret;
    ras_op_t    squash_op;
    ras_entry_t squash_ret;
    ras_op_t    update_op;
    ras_entry_t update_ret;
    logic       lookup_act;
    logic       commit_valid;
    ras_entry_t spec_entry;
    ras_entry_t commit_entry;
    logic       stale;
    logic       empty;
    ras_ckpt_t  ckpt;

    // ************************************************************
    // slot decode
    // ************************************************************

    ras_slot_decode decode_lookup (
        .start_addr (lookup_start_addr),
        .offset     (lookup_offset),
        .br_type    (lookup_br_type),
        .rvc        (lookup_rvc),
        .op         (lookup_op),
        .ret_addr   (lookup_ret)
    );

    ras_slot_decode decode_squash (
        .start_addr (squash_start_addr),
        .offset     (squash_offset),
        .br_type    (squash_br_type),
        .rvc        (squash_rvc),
        .op         (squash_op),
        .ret_addr   (squash_ret)
    );

    ras_slot_decode decode_update (
        .start_addr (update_start_addr),
        .offset     (update_offset),
        .br_type    (update_br_type),
        .rvc        (update_rvc),
        .op         (update_op),
        .ret_addr   (update_ret)
    );

    assign lookup_act   = lookup & ~squash;       // squash owns the cycle
    assign commit_valid = update & update_taken & (update_op != RAS_NONE);

    // ************************************************************
    // stack and prediction
    // ************************************************************

    ras_stack stack0 (
        .clk          (clk),
        .rst          (rst),
        .lookup_valid (lookup_act),
        .lookup_op    (lookup_op),
        .lookup_addr  (lookup_ret),
        .squash       (squash),
        .squash_front (squash_front),
        .squash_op    (squash_op),
        .squash_addr  (squash_ret),
        .squash_ckpt  (squash_ckpt),
        .commit_valid (commit_valid),
        .commit_op    (update_op),
        .commit_addr  (update_ret),
        .spec_entry   (spec_entry),
        .commit_entry (commit_entry),
        .stale        (stale),
        .empty        (empty),
        .ckpt         (ckpt)
    );

    ras_target_select select0 (
        .clk          (clk),
        .rst          (rst),
        .spec_entry   (spec_entry),
        .commit_entry (commit_entry),
        .stale        (stale),
        .empty        (empty),
        .ckpt         (ckpt),
        .lookup       (lookup_act),
        .pred_valid   (pred_valid),
        .pred_target  (pred_target),
        .pred_ckpt    (pred_ckpt)
    );

endmodule

// File: verification/ras_checker.sv
`include "ras_defines.svh"

module ras_checker (
    input logic                  clk,
    input logic                  rst,
    input logic                  pred_valid,
    input logic                  squash,
    input logic                  full,
    input logic                  empty,
    input logic [`RAS_WIDTH-1:0] commit_top
);

    // ************************************************************
    // reset and occupancy
    // ************************************************************

    a_reset_quiet: assert property (@(posedge clk) rst |=> !pred_valid)
        else $error("pred_valid high in the cycle after reset");

    // no single push or pop spans the whole stack
    a_full_empty: assert property (@(posedge clk) disable iff (rst)
        !squash && (full || empty) |=> !(full && $past(empty)) && !(empty && $past(full)))
        else $error("stack went between full and empty in one cycle");

    // commit side moves one entry at most
    a_commit_step: assert property (@(posedge clk) disable iff (rst)
        commit_top == $past(commit_top) || commit_top == $past(commit_top) + 1'b1 ||
        commit_top == $past(commit_top) - 1'b1)
        else $error("commit_top jumped by more than one entry");

endmodule

bind ras_predictor ras_checker chk0 (
    .clk        (clk),
    .rst        (rst),
    .pred_valid (pred_valid),
    .squash     (squash),
    .full       (stack0.full),
    .empty      (empty),
    .commit_top (stack0.commit_top)
);

// File: verification/ras_tb.sv
`include "ras_defines.svh"

module ras_tb;
    import bpu_types_pkg::*;
    import ras_pkg::*;

    localparam int NUM_CYCLES = 1200;
    localparam int MAX_CYCLES = NUM_CYCLES + 64;    // reset, drain and slack

    typedef struct packed {
        logic                    look;
        logic                    valid;
        logic                    known;
        logic [`VADDR_WIDTH-1:0] target;
        ras_ckpt_t               ckpt;
    } pred_exp_t;

    logic clk, rst, lookup, squash, squash_front, update, update_taken;
    logic [`VADDR_WIDTH-1:0] lookup_start_addr, squash_start_addr, update_start_addr;
    logic [`SLOT_OFFSET_WIDTH-1:0] lookup_offset, squash_offset, update_offset;
    br_type_t lookup_br_type, squash_br_type, update_br_type;
    logic lookup_rvc, squash_rvc, update_rvc, pred_valid;
    ras_ckpt_t squash_ckpt, pred_ckpt, ck;
    logic [`VADDR_WIDTH-1:0] pred_target;

    logic [31:0] lfsr;
    logic lk, sq, fr, up, tk;
    logic [`VADDR_WIDTH-1:0] s_addr [3];        // lookup, squash, update slots
    logic [`SLOT_OFFSET_WIDTH-1:0] s_off [3];
    br_type_t s_type [3];
    logic s_rvc [3];

    logic [`RAS_WIDTH-1:0] m_top, m_bot, m_ctop;
    logic m_tdir, m_bdir;
    logic [`RAS_SIZE-1:0] m_speculate, m_spop, m_spush, m_spec_ok, m_comm_ok;
    logic [`VADDR_WIDTH-1:0] m_spec [`RAS_SIZE];
    logic [`VADDR_WIDTH-1:0] m_comm [`RAS_SIZE];
    ras_ckpt_t ckpt_hist [8];
    logic [2:0] hist_wr;
    pred_exp_t nxt, cur;
    int mismatches, other_errs, cycles;

    ras_predictor dut0 (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: run went past %0d cycles", MAX_CYCLES);
            $display("Regression failed");
            $finish;
        end
    end

    // ************************************************************
    // random source
    // ************************************************************

    function automatic logic take_bit();
        logic b;
        b = lfsr[0];
        lfsr = lfsr >> 1;
        if (b) lfsr = lfsr ^ 32'h8020_0003;     // x^32 + x^22 + x^2 + x + 1
        return b;
    endfunction

    function automatic logic [`VADDR_WIDTH-1:0] take_bits(input int n);
        logic [`VADDR_WIDTH-1:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[`VADDR_WIDTH-2:0], take_bit()};
        end
        return v;
    endfunction

    // phase 0 fills, phase 1 drains, phase 2 mixes
    function automatic br_type_t pick_type(input int phase);
        logic [2:0] r;
        r = 3'(take_bits(3));
        if (phase == 0) return (r < 3'd6) ? CALL : DIRECT;
        if (phase == 1) return (r < 3'd6) ? RET : INDIRECT;
        case (r)
            3'd0, 3'd1: return CALL;
            3'd2, 3'd3: return RET;
            3'd4:       return RET_CALL;
            3'd5:       return DIRECT;
            default:    return INDIRECT;
        endcase
    endfunction

    // ************************************************************
    // reference model
    // ************************************************************

    function automatic logic [1:0] slot_op(input br_type_t t);
        case (t)
            CALL:     return 2'b10;
            RET:      return 2'b01;
            RET_CALL: return 2'b11;
            default:  return 2'b00;
        endcase
    endfunction

    function automatic logic [`VADDR_WIDTH-1:0] slot_ret(input int k);
        return s_addr[k] + (`VADDR_WIDTH'(s_off[k]) << `INST_OFFSET) +
               (s_rvc[k] ? `VADDR_WIDTH'(2) : `VADDR_WIDTH'(4));
    endfunction

    task automatic advance_model();
        logic [1:0] op;
        logic [1:0] cop;
        logic [`VADDR_WIDTH-1:0] addr;
        logic [`RAS_WIDTH:0] bt, bb;
        logic pop, push, bempty, bfull, stale;
        logic [`RAS_WIDTH-1:0] w, cw, idx;
        logic [`RAS_SIZE-1:0] live;
        idx = m_top - 1'b1;                     // prediction uses pre-op state
        stale = m_speculate[idx] && !m_spush[idx];
        nxt.look = lk && !sq;
        nxt.valid = nxt.look && !(m_tdir == m_bdir && m_top == m_bot);
        nxt.known = stale ? m_comm_ok[idx] : m_spec_ok[idx];
        nxt.target = stale ? m_comm[idx] : m_spec[idx];
        nxt.ckpt = {m_top, m_tdir, m_bot, m_bdir};
        if (nxt.look) begin
            ckpt_hist[hist_wr] = nxt.ckpt;
            hist_wr = hist_wr + 1'b1;
        end
        op = sq ? slot_op(s_type[1]) : (lk ? slot_op(s_type[0]) : 2'b00);
        addr = sq ? slot_ret(1) : slot_ret(0);
        bt = sq ? {ck.tdir, ck.top} : {m_tdir, m_top};
        bb = sq ? {ck.bdir, ck.bottom} : {m_bdir, m_bot};
        bempty = (bt == bb);
        bfull = (bt[`RAS_WIDTH-1:0] == bb[`RAS_WIDTH-1:0]) && (bt[`RAS_WIDTH] != bb[`RAS_WIDTH]);
        pop = op[0] && !bempty;
        push = op[1];
        w = pop ? bt[`RAS_WIDTH-1:0] - 1'b1 : bt[`RAS_WIDTH-1:0];
        if (sq && !fr) begin
            for (int i = 0; i < `RAS_SIZE; i++) begin
                live[i] = (ck.tdir == ck.bdir) ? (i >= ck.bottom && i < ck.top)
                                               : (i >= ck.bottom || i < ck.top);
            end
            m_speculate = m_speculate | (live & m_spop & m_spush);
            m_spop = '0;
            m_spush = '0;
        end
        if (pop) m_spop[w] = 1'b1;
        if (push) begin
            m_spush[w] = 1'b1;
            m_spec[w] = addr;
            m_spec_ok[w] = 1'b1;
        end
        if (push && !pop) begin
            bt = bt + 1'b1;
            if (bfull) bb = bb + 1'b1;          // oldest entry drops out
        end else if (pop && !push) begin
            bt = bt - 1'b1;
        end
        {m_tdir, m_top} = bt;
        {m_bdir, m_bot} = bb;
        cop = slot_op(s_type[2]);
        if (up && tk && cop != 2'b00) begin
            cw = cop[0] ? m_ctop - 1'b1 : m_ctop;
            if (cop[1]) begin
                m_comm[cw] = slot_ret(2);
                m_comm_ok[cw] = 1'b1;
                m_speculate[cw] = 1'b0;         // repaired by the commit
            end
            if (cop == 2'b10) m_ctop = m_ctop + 1'b1;
            else if (cop == 2'b01) m_ctop = m_ctop - 1'b1;
        end
    endtask

    task automatic drive_inputs();
        lookup            <= lk;
        lookup_start_addr <= s_addr[0];
        lookup_offset     <= s_off[0];
        lookup_br_type    <= s_type[0];
        lookup_rvc        <= s_rvc[0];
        squash            <= sq;
        squash_front      <= fr;
        squash_start_addr <= s_addr[1];
        squash_offset     <= s_off[1];
        squash_br_type    <= s_type[1];
        squash_rvc        <= s_rvc[1];
        squash_ckpt       <= ck;
        update            <= up;
        update_taken      <= tk;
        update_start_addr <= s_addr[2];
        update_offset     <= s_off[2];
        update_br_type    <= s_type[2];
        update_rvc        <= s_rvc[2];
    endtask

    // ************************************************************
    // stimulus and checks
    // ************************************************************

    initial begin
        int phase;
        lfsr = 32'h208e_1ff5;
        {lk, sq, fr, up, tk} = '0;
        ck = '0;
        for (int k = 0; k < 3; k++) begin
            s_addr[k] = '0;
            s_off[k] = '0;
            s_type[k] = DIRECT;
            s_rvc[k] = 1'b0;
        end
        for (int h = 0; h < 8; h++) ckpt_hist[h] = '0;
        {m_top, m_bot, m_ctop, m_tdir, m_bdir} = '0;
        {m_speculate, m_spop, m_spush, m_spec_ok, m_comm_ok} = '0;
        hist_wr = '0;
        cur = '0;
        rst = 1'b1;
        drive_inputs();
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        for (int cyc = 0; cyc <= NUM_CYCLES; cyc++) begin
            @(posedge clk);
            phase = (cyc % 200 < 40) ? 0 : ((cyc % 200 < 100) ? 1 : 2);
            for (int k = 0; k < 3; k++) begin
                s_addr[k] = take_bits(`VADDR_WIDTH);
                s_off[k] = `SLOT_OFFSET_WIDTH'(take_bits(`SLOT_OFFSET_WIDTH));
                s_type[k] = pick_type(k == 0 ? phase : 2);
                s_rvc[k] = take_bit();
            end
            lk = (cyc < NUM_CYCLES) && (take_bit() | take_bit());
            sq = (cyc < NUM_CYCLES) && phase == 2 && (take_bits(3) == '0);
            fr = take_bit();
            ck = ckpt_hist[3'(take_bits(3))];   // replay an earlier pred_ckpt
            up = (cyc < NUM_CYCLES) && take_bit();
            tk = take_bit() | take_bit();
            drive_inputs();
            advance_model();
            @(negedge clk);
            if ($isunknown(pred_valid)) begin
                $display("pred_valid is unknown at cycle %0d", cyc);
                other_errs++;
            end else if (pred_valid !== cur.valid) begin
                $display("MISMATCH pred_valid: got %h expected %h at cycle %0d",
                         pred_valid, cur.valid, cyc);
                mismatches++;
            end
            if (cur.look && cur.valid && cur.known && pred_target !== cur.target) begin
                $display("MISMATCH pred_target: got %h expected %h at cycle %0d",
                         pred_target, cur.target, cyc);
                mismatches++;
            end
            if (cur.look && pred_ckpt !== cur.ckpt) begin
                $display("MISMATCH pred_ckpt: got %h expected %h at cycle %0d",
                         pred_ckpt, cur.ckpt, cyc);
                mismatches++;
            end
            cur = nxt;
        end
        $display("closing: %0d mismatches, %0d other errors", mismatches, other_errs);
        if (mismatches == 0 && other_errs == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

// File: sources.f
+incdir+include
logic/bpu_types_pkg.sv
logic/ras_pkg.sv
logic/ras_slot_decode.sv
logic/ras_stack.sv
logic/ras_target_select.sv
logic/ras_predictor.sv
verification/ras_checker.sv
verification/ras_tb.sv

// File: Makefile
LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run ras_tb and check the log"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module ras_tb \
		-f sources.f -Mdir obj_dir
	./obj_dir/Vras_tb | tee $(LOG)
	grep -q "Regression passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
